/* aib_lane_pkg.sv */
////////////////////////////////////////////////////////////
// PHY lane format shared by the transmit and receive paths.
// Each 40-bit lane holds 38 payload bits, a strobe bit and
// a marker bit at the top.
////////////////////////////////////////////////////////////

`default_nettype none

package aib_lane_pkg;

  // One PHY lane
  localparam int LANE_W = 40;

  // Per-lane framing bits
  localparam int MRK_BIT = 39;
  localparam int STB_BIT = 38;

  // Payload sits in bits 37..0 of every lane
  localparam int LANE_PAYLOAD_W = 38;

  // Lanes needed to carry a link word, rounded up.
  // Lane k holds link word bits 38k .. 38k+37, and
  // anything past the top of the word is zero padding.
  function automatic int num_lanes(input int flit_w);
    return (flit_w + LANE_PAYLOAD_W - 1) / LANE_PAYLOAD_W;
  endfunction

endpackage

`default_nettype wire

/* ll_auto_sync.sv */
////////////////////////////////////////////////////////////
// Link bring-up sequencer.
// Delays tx online, then rx online, then the strobe, each
// by a programmable cycle count, and drives the persistent
// marker and the debug status words.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ll_auto_sync (
  input  logic        clk_wr,
  input  logic        rst_n,

  input  logic        tx_online,
  input  logic        rx_online,

  input  logic [15:0] delay_x_value,
  input  logic [15:0] delay_y_value,
  input  logic [15:0] delay_z_value,

  output logic        tx_online_delay,
  output logic        rx_online_delay,
  output logic        stb_userbit,
  output logic        mrk_userbit,

  output logic [31:0] rx_downstream_debug_status,
  output logic [31:0] tx_upstream_debug_status
);

  // Stage 0 is tx online, 1 is rx online, 2 is the strobe
  logic [2:0]  stage_en;
  logic [2:0]  stage_hit;
  logic [2:0]  stage_done;
  logic [15:0] stage_dly [3];

  assign stage_dly[0] = delay_x_value;
  assign stage_dly[1] = delay_y_value;
  assign stage_dly[2] = delay_z_value;

  ////////////////////////////////////////////////////////////
  // Stage enables

  assign stage_en[0] = tx_online;
  assign stage_en[1] = rx_online & stage_done[0];
  // Strobe starts counting on the edge where tx online rises
  assign stage_en[2] = stage_hit[0];

  ////////////////////////////////////////////////////////////
  // Delay counters

  for (genvar i = 0; i < 3; i++) begin : g_stage
    logic [15:0] cnt;
    logic        done;

    // Next value of the stage output; delay 0 rises at once
    assign stage_hit[i]  = stage_en[i] & (done | (cnt == stage_dly[i]));
    assign stage_done[i] = done;

    always_ff @(posedge clk_wr) begin
      if (!rst_n) begin
        cnt  <= '0;
        done <= 1'b0;
      end else begin
        done <= stage_hit[i];
        if (!stage_en[i]) begin
          cnt <= '0;
        end else if (!stage_hit[i]) begin
          cnt <= cnt + 16'd1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs

  assign tx_online_delay = stage_done[0];
  assign rx_online_delay = stage_done[1];
  assign stb_userbit     = stage_done[2];

  // Persistent marker, up for as long as tx is online
  assign mrk_userbit = stage_done[0];

  // Online flags at bits 19 and 18
  assign rx_downstream_debug_status = {12'h0, tx_online_delay, rx_online_delay, 18'h0};
  assign tx_upstream_debug_status   = {12'h0, tx_online_delay, rx_online_delay, 18'h0};

endmodule

`default_nettype wire

/* lpif_flit_pkg.sv */
////////////////////////////////////////////////////////////
// Flit field layout for the logic-link slave.
// Widths of the non-data fields and their offsets above the
// data field inside the link word, LSB first.
////////////////////////////////////////////////////////////

`default_nettype none

package lpif_flit_pkg;

  // Field widths
  localparam int STATE_W  = 4;
  localparam int PROTID_W = 2;
  localparam int CRC_W    = 16;

  // Offsets above the data field, LSB to MSB
  localparam int DVALID_OFS    = 0;
  localparam int CRC_OFS       = DVALID_OFS + 1;
  localparam int CRC_VALID_OFS = CRC_OFS + CRC_W;
  localparam int VALID_OFS     = CRC_VALID_OFS + 1;
  localparam int PROTID_OFS    = VALID_OFS + 1;
  localparam int STATE_OFS     = PROTID_OFS + PROTID_W;

  // All non-data fields together, 25 bits
  localparam int CTRL_W = STATE_OFS + STATE_W;

  // Link word width for a given data width
  function automatic int flit_width(input int data_w);
    return data_w + CTRL_W;
  endfunction

endpackage

`default_nettype wire

/* lpif_slave_concat.sv */
////////////////////////////////////////////////////////////
// PHY lane striping.
// Transmit spreads the link word over the lanes with marker
// and strobe, registered and zero while offline. Receive
// checks every lane's framing and registers word or zero.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lpif_slave_concat #(
  parameter int DATA_W = 128
) (
  input  logic clk_wr,
  input  logic rst_n,

  // Sequencer controls
  input  logic tx_online_delay,
  input  logic rx_online_delay,
  input  logic stb_userbit,
  input  logic mrk_userbit,

  // Link words
  input  logic [lpif_flit_pkg::flit_width(DATA_W)-1:0] tx_flit,
  output logic [lpif_flit_pkg::flit_width(DATA_W)-1:0] rx_flit,

  // PHY lanes
  output logic [aib_lane_pkg::num_lanes(lpif_flit_pkg::flit_width(DATA_W))-1:0]
               [aib_lane_pkg::LANE_W-1:0] tx_phy,
  input  logic [aib_lane_pkg::num_lanes(lpif_flit_pkg::flit_width(DATA_W))-1:0]
               [aib_lane_pkg::LANE_W-1:0] rx_phy
);

  localparam int FLIT_W    = lpif_flit_pkg::flit_width(DATA_W);
  localparam int NUM_LANES = aib_lane_pkg::num_lanes(FLIT_W);
  localparam int PAY_W     = aib_lane_pkg::LANE_PAYLOAD_W;
  localparam int PAD_W     = NUM_LANES * PAY_W;

  logic [PAD_W-1:0] tx_pad;
  logic [PAD_W-1:0] rx_pad;
  logic             rx_ok;

  logic [NUM_LANES-1:0][aib_lane_pkg::LANE_W-1:0] tx_lane;

  ////////////////////////////////////////////////////////////
  // Transmit

  always_comb begin
    // Bits above the word go out as zero
    tx_pad             = '0;
    tx_pad[FLIT_W-1:0] = tx_flit;
    for (int k = 0; k < NUM_LANES; k++) begin
      tx_lane[k][PAY_W-1:0]                = tx_pad[k*PAY_W +: PAY_W];
      tx_lane[k][aib_lane_pkg::STB_BIT]    = stb_userbit;
      tx_lane[k][aib_lane_pkg::MRK_BIT]    = mrk_userbit;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (!rst_n || !tx_online_delay) begin
      tx_phy <= '0;
    end else begin
      tx_phy <= tx_lane;
    end
  end

  ////////////////////////////////////////////////////////////
  // Receive

  // Word accepted only with every lane framed and rx online
  always_comb begin
    rx_ok = rx_online_delay;
    for (int k = 0; k < NUM_LANES; k++) begin
      rx_ok = rx_ok & rx_phy[k][aib_lane_pkg::MRK_BIT] & rx_phy[k][aib_lane_pkg::STB_BIT];
      rx_pad[k*PAY_W +: PAY_W] = rx_phy[k][PAY_W-1:0];
    end
  end

  always_ff @(posedge clk_wr) begin
    if (!rst_n || !rx_ok) begin
      rx_flit <= '0;
    end else begin
      // Padding lanes bits are dropped here
      rx_flit <= rx_pad[FLIT_W-1:0];
    end
  end

endmodule

`default_nettype wire

/* lpif_slave_name.sv */
////////////////////////////////////////////////////////////
// Flit field mapping.
// Packs the upstream LPIF fields into the link word and
// splits the received link word into downstream fields.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lpif_slave_name #(
  parameter int DATA_W = 128
) (
  // Upstream fields
  input  logic [lpif_flit_pkg::STATE_W-1:0]  ustrm_state,
  input  logic [lpif_flit_pkg::PROTID_W-1:0] ustrm_protid,
  input  logic [DATA_W-1:0]                  ustrm_data,
  input  logic                               ustrm_dvalid,
  input  logic [lpif_flit_pkg::CRC_W-1:0]    ustrm_crc,
  input  logic                               ustrm_crc_valid,
  input  logic                               ustrm_valid,

  // Link words
  output logic [lpif_flit_pkg::flit_width(DATA_W)-1:0] tx_flit,
  input  logic [lpif_flit_pkg::flit_width(DATA_W)-1:0] rx_flit,

  // Downstream fields
  output logic [lpif_flit_pkg::STATE_W-1:0]  dstrm_state,
  output logic [lpif_flit_pkg::PROTID_W-1:0] dstrm_protid,
  output logic [DATA_W-1:0]                  dstrm_data,
  output logic                               dstrm_dvalid,
  output logic [lpif_flit_pkg::CRC_W-1:0]    dstrm_crc,
  output logic                               dstrm_crc_valid,
  output logic                               dstrm_valid
);

  // Absolute field positions in the link word
  localparam int DVALID_POS    = DATA_W + lpif_flit_pkg::DVALID_OFS;
  localparam int CRC_LSB       = DATA_W + lpif_flit_pkg::CRC_OFS;
  localparam int CRC_VALID_POS = DATA_W + lpif_flit_pkg::CRC_VALID_OFS;
  localparam int VALID_POS     = DATA_W + lpif_flit_pkg::VALID_OFS;
  localparam int PROTID_LSB    = DATA_W + lpif_flit_pkg::PROTID_OFS;
  localparam int STATE_LSB     = DATA_W + lpif_flit_pkg::STATE_OFS;

  ////////////////////////////////////////////////////////////
  // Upstream pack

  assign tx_flit[DATA_W-1:0]                               = ustrm_data;
  assign tx_flit[DVALID_POS]                               = ustrm_dvalid;
  assign tx_flit[CRC_LSB +: lpif_flit_pkg::CRC_W]          = ustrm_crc;
  assign tx_flit[CRC_VALID_POS]                            = ustrm_crc_valid;
  assign tx_flit[VALID_POS]                                = ustrm_valid;
  assign tx_flit[PROTID_LSB +: lpif_flit_pkg::PROTID_W]    = ustrm_protid;
  assign tx_flit[STATE_LSB +: lpif_flit_pkg::STATE_W]      = ustrm_state;

  ////////////////////////////////////////////////////////////
  // Downstream unpack

  assign dstrm_data      = rx_flit[DATA_W-1:0];
  assign dstrm_dvalid    = rx_flit[DVALID_POS];
  assign dstrm_crc       = rx_flit[CRC_LSB +: lpif_flit_pkg::CRC_W];
  assign dstrm_crc_valid = rx_flit[CRC_VALID_POS];
  assign dstrm_valid     = rx_flit[VALID_POS];
  assign dstrm_protid    = rx_flit[PROTID_LSB +: lpif_flit_pkg::PROTID_W];
  assign dstrm_state     = rx_flit[STATE_LSB +: lpif_flit_pkg::STATE_W];

endmodule

`default_nettype wire

/* lpif_slave_top.f */
lpif_flit_pkg.sv
aib_lane_pkg.sv
ll_auto_sync.sv
lpif_slave_name.sv
lpif_slave_concat.sv
lpif_slave_top.sv
tb_lpif_slave_top.sv

/* lpif_slave_top.sv */
////////////////////////////////////////////////////////////
// Logic-link slave top level.
// Ties the bring-up sequencer, the flit field mapping and
// the lane striping together on a single clock.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lpif_slave_top #(
  parameter int DATA_W = 128
) (
  input  logic        clk_wr,
  input  logic        rst_n,

  // Link control
  input  logic        tx_online,
  input  logic        rx_online,
  input  logic [15:0] delay_x_value,
  input  logic [15:0] delay_y_value,
  input  logic [15:0] delay_z_value,

  // Upstream channel
  input  logic [lpif_flit_pkg::STATE_W-1:0]  ustrm_state,
  input  logic [lpif_flit_pkg::PROTID_W-1:0] ustrm_protid,
  input  logic [DATA_W-1:0]                  ustrm_data,
  input  logic                               ustrm_dvalid,
  input  logic [lpif_flit_pkg::CRC_W-1:0]    ustrm_crc,
  input  logic                               ustrm_crc_valid,
  input  logic                               ustrm_valid,

  // Downstream channel
  output logic [lpif_flit_pkg::STATE_W-1:0]  dstrm_state,
  output logic [lpif_flit_pkg::PROTID_W-1:0] dstrm_protid,
  output logic [DATA_W-1:0]                  dstrm_data,
  output logic                               dstrm_dvalid,
  output logic [lpif_flit_pkg::CRC_W-1:0]    dstrm_crc,
  output logic                               dstrm_crc_valid,
  output logic                               dstrm_valid,

  // PHY lanes
  output logic [aib_lane_pkg::num_lanes(lpif_flit_pkg::flit_width(DATA_W))-1:0]
               [aib_lane_pkg::LANE_W-1:0] tx_phy,
  input  logic [aib_lane_pkg::num_lanes(lpif_flit_pkg::flit_width(DATA_W))-1:0]
               [aib_lane_pkg::LANE_W-1:0] rx_phy,

  // Debug status
  output logic [31:0] rx_downstream_debug_status,
  output logic [31:0] tx_upstream_debug_status
);

  localparam int FLIT_W = lpif_flit_pkg::flit_width(DATA_W);

  logic              tx_online_delay;
  logic              rx_online_delay;
  logic              stb_userbit;
  logic              mrk_userbit;
  logic [FLIT_W-1:0] tx_flit;
  logic [FLIT_W-1:0] rx_flit;

  ////////////////////////////////////////////////////////////
  // Bring-up

  ll_auto_sync ll_auto_sync_i (
    .clk_wr                     (clk_wr),
    .rst_n                      (rst_n),
    .tx_online                  (tx_online),
    .rx_online                  (rx_online),
    .delay_x_value              (delay_x_value),
    .delay_y_value              (delay_y_value),
    .delay_z_value              (delay_z_value),
    .tx_online_delay            (tx_online_delay),
    .rx_online_delay            (rx_online_delay),
    .stb_userbit                (stb_userbit),
    .mrk_userbit                (mrk_userbit),
    .rx_downstream_debug_status (rx_downstream_debug_status),
    .tx_upstream_debug_status   (tx_upstream_debug_status)
  );

  ////////////////////////////////////////////////////////////
  // Field mapping

  lpif_slave_name #(
    .DATA_W (DATA_W)
  ) lpif_slave_name_i (
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid),
    .tx_flit         (tx_flit),
    .rx_flit         (rx_flit),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid)
  );

  ////////////////////////////////////////////////////////////
  // Lane striping

  lpif_slave_concat #(
    .DATA_W (DATA_W)
  ) lpif_slave_concat_i (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .stb_userbit     (stb_userbit),
    .mrk_userbit     (mrk_userbit),
    .tx_flit         (tx_flit),
    .rx_flit         (rx_flit),
    .tx_phy          (tx_phy),
    .rx_phy          (rx_phy)
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Compile and run the logic-link slave testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_lpif_slave_top \
  -f lpif_slave_top.f \
  -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx '>>> PASS'; then
  exit 0
fi
exit 1

/* tb_lpif_slave_top.sv */
////////////////////////////////////////////////////////////
// Directed testbench for the logic-link slave top level.
// Covers reset, bring-up timing, transmit and receive lane
// mapping, receive framing checks and a tx to rx loopback.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_lpif_slave_top;

  localparam int DATA_W    = 128;
  localparam int ST_W      = lpif_flit_pkg::STATE_W;
  localparam int PID_W     = lpif_flit_pkg::PROTID_W;
  localparam int CRC_W     = lpif_flit_pkg::CRC_W;
  localparam int FLIT_W    = DATA_W + ST_W + PID_W + CRC_W + 3;
  localparam int PAY_W     = aib_lane_pkg::LANE_PAYLOAD_W;
  localparam int LANE_W    = aib_lane_pkg::LANE_W;
  localparam int NUM_LANES = (FLIT_W + PAY_W - 1) / PAY_W;
  localparam int STB       = aib_lane_pkg::STB_BIT;
  localparam int MRK       = aib_lane_pkg::MRK_BIT;

  // Field order from the LSB is data, dvalid, crc, crc_valid, valid, protid, state
  localparam int P_DVALID    = DATA_W;
  localparam int P_CRC       = DATA_W + 1;
  localparam int P_CRC_VALID = P_CRC + CRC_W;
  localparam int P_VALID     = P_CRC_VALID + 1;
  localparam int P_PROTID    = P_VALID + 1;
  localparam int P_STATE     = P_PROTID + PID_W;

  localparam int DLY_X      = 5;
  localparam int DLY_Y      = 3;
  localparam int DLY_Z      = 2;
  localparam int LOOP_FLITS = 50;
  // Directed tests take about 150 cycles plus the loopback run
  localparam int TIMEOUT_CYCLES = 10 * (150 + LOOP_FLITS);

  logic              clk;
  logic              rst_n;
  logic              tx_online;
  logic              rx_online;
  logic [15:0]       delay_x_value;
  logic [15:0]       delay_y_value;
  logic [15:0]       delay_z_value;
  logic [ST_W-1:0]   ustrm_state;
  logic [PID_W-1:0]  ustrm_protid;
  logic [DATA_W-1:0] ustrm_data;
  logic              ustrm_dvalid;
  logic [CRC_W-1:0]  ustrm_crc;
  logic              ustrm_crc_valid;
  logic              ustrm_valid;
  logic [ST_W-1:0]   dstrm_state;
  logic [PID_W-1:0]  dstrm_protid;
  logic [DATA_W-1:0] dstrm_data;
  logic              dstrm_dvalid;
  logic [CRC_W-1:0]  dstrm_crc;
  logic              dstrm_crc_valid;
  logic              dstrm_valid;
  logic [31:0]       rx_downstream_debug_status;
  logic [31:0]       tx_upstream_debug_status;
  logic              loopback;

  logic [NUM_LANES-1:0][LANE_W-1:0] tx_phy;
  logic [NUM_LANES-1:0][LANE_W-1:0] rx_phy;
  logic [NUM_LANES-1:0][LANE_W-1:0] rx_phy_drv;

  logic [31:0] lfsr;
  int          errors;
  int          pass_count;
  int          fail_count;
  int          cycles = 0;

  assign rx_phy = loopback ? tx_phy : rx_phy_drv;

  lpif_slave_top #(
    .DATA_W (DATA_W)
  ) dut (
    .clk_wr                     (clk),
    .rst_n                      (rst_n),
    .tx_online                  (tx_online),
    .rx_online                  (rx_online),
    .delay_x_value              (delay_x_value),
    .delay_y_value              (delay_y_value),
    .delay_z_value              (delay_z_value),
    .ustrm_state                (ustrm_state),
    .ustrm_protid               (ustrm_protid),
    .ustrm_data                 (ustrm_data),
    .ustrm_dvalid               (ustrm_dvalid),
    .ustrm_crc                  (ustrm_crc),
    .ustrm_crc_valid            (ustrm_crc_valid),
    .ustrm_valid                (ustrm_valid),
    .dstrm_state                (dstrm_state),
    .dstrm_protid               (dstrm_protid),
    .dstrm_data                 (dstrm_data),
    .dstrm_dvalid               (dstrm_dvalid),
    .dstrm_crc                  (dstrm_crc),
    .dstrm_crc_valid            (dstrm_crc_valid),
    .dstrm_valid                (dstrm_valid),
    .tx_phy                     (tx_phy),
    .rx_phy                     (rx_phy),
    .rx_downstream_debug_status (rx_downstream_debug_status),
    .tx_upstream_debug_status   (tx_upstream_debug_status)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display(">>> FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers

  task automatic step_cycle;
    @(posedge clk);
    #1;
  endtask

  task automatic compare_hex(input string name, input logic [FLIT_W-1:0] got,
                             input logic [FLIT_W-1:0] exp);
    assert (got === exp) else begin
      $display("ERR %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    assert (cond) else begin
      $display("%s", msg);
      errors++;
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_flit(output logic [FLIT_W-1:0] f);
    for (int b = 0; b < FLIT_W; b++) begin
      lfsr = lfsr_next(lfsr);
      f[b] = lfsr[0];
    end
  endtask

  task automatic drive_ustrm(input logic [FLIT_W-1:0] f);
    ustrm_data      = f[DATA_W-1:0];
    ustrm_dvalid    = f[P_DVALID];
    ustrm_crc       = f[P_CRC +: CRC_W];
    ustrm_crc_valid = f[P_CRC_VALID];
    ustrm_valid     = f[P_VALID];
    ustrm_protid    = f[P_PROTID +: PID_W];
    ustrm_state     = f[P_STATE +: ST_W];
  endtask

  // Reference lane image with marker, strobe and 38 payload bits
  function automatic logic [NUM_LANES-1:0][LANE_W-1:0] pack_lanes(
    input logic [FLIT_W-1:0] flit, input logic mrk, input logic stb);
    logic [NUM_LANES*PAY_W-1:0]       padded;
    logic [NUM_LANES-1:0][LANE_W-1:0] lanes;
    padded             = '0;
    padded[FLIT_W-1:0] = flit;
    for (int k = 0; k < NUM_LANES; k++) begin
      lanes[k] = {mrk, stb, padded[k*PAY_W +: PAY_W]};
    end
    return lanes;
  endfunction

  task automatic check_dstrm(input logic [FLIT_W-1:0] f);
    compare_hex("dstrm_data", FLIT_W'(dstrm_data), FLIT_W'(f[DATA_W-1:0]));
    compare_hex("dstrm_dvalid", FLIT_W'(dstrm_dvalid), FLIT_W'(f[P_DVALID]));
    compare_hex("dstrm_crc", FLIT_W'(dstrm_crc), FLIT_W'(f[P_CRC +: CRC_W]));
    compare_hex("dstrm_crc_valid", FLIT_W'(dstrm_crc_valid), FLIT_W'(f[P_CRC_VALID]));
    compare_hex("dstrm_valid", FLIT_W'(dstrm_valid), FLIT_W'(f[P_VALID]));
    compare_hex("dstrm_protid", FLIT_W'(dstrm_protid), FLIT_W'(f[P_PROTID +: PID_W]));
    compare_hex("dstrm_state", FLIT_W'(dstrm_state), FLIT_W'(f[P_STATE +: ST_W]));
  endtask

  task automatic check_tx_phy(input logic [NUM_LANES-1:0][LANE_W-1:0] exp);
    for (int k = 0; k < NUM_LANES; k++) begin
      compare_hex($sformatf("tx_phy[%0d]", k), FLIT_W'(tx_phy[k]), FLIT_W'(exp[k]));
    end
  endtask

  task automatic finish_test(input string name);
    if (errors == 0) begin
      $display("test %s: ok", name);
      pass_count++;
    end else begin
      $display("test %s: %0d errors", name, errors);
      fail_count++;
    end
    errors = 0;
  endtask

  // Waits until rx is online and the strobe is on the lanes
  task automatic bring_online;
    int n;
    tx_online = 1'b1;
    rx_online = 1'b1;
    n = 0;
    while (!(tx_phy[0][STB] && rx_downstream_debug_status[18]) && n < 100) begin
      step_cycle;
      n++;
    end
    check_true(tx_phy[0][STB] && rx_downstream_debug_status[18],
               "link did not come online within 100 cycles");
  endtask

  ////////////////////////////////////////////////////////////
  // Tests

  task automatic test_reset;
    step_cycle;
    check_tx_phy('0);
    compare_hex("dstrm_valid", FLIT_W'(dstrm_valid), '0);
    compare_hex("dstrm_dvalid", FLIT_W'(dstrm_dvalid), '0);
    compare_hex("dstrm_crc_valid", FLIT_W'(dstrm_crc_valid), '0);
    compare_hex("rx_downstream_debug_status", FLIT_W'(rx_downstream_debug_status), '0);
    compare_hex("tx_upstream_debug_status", FLIT_W'(tx_upstream_debug_status), '0);
    finish_test("reset state");
  endtask

  task automatic test_online;
    int n;
    int mrk_at;
    int stb_at;
    int rx_at;
    rx_online = 1'b1;
    tx_online = 1'b1;
    // First edge that samples tx_online
    step_cycle;
    n = 0;
    while (!tx_upstream_debug_status[19] && n < 64) begin
      step_cycle;
      n++;
    end
    compare_hex("tx_online_delay rise cycles", FLIT_W'(n), FLIT_W'(DLY_X));
    // Lanes lag the sequencer by the tx register; rx counts from the next edge
    mrk_at = -1;
    stb_at = -1;
    rx_at  = -1;
    for (n = 1; n <= 64 && (stb_at < 0 || rx_at < 0); n++) begin
      step_cycle;
      if (mrk_at < 0 && tx_phy[0][MRK]) mrk_at = n;
      if (stb_at < 0 && tx_phy[0][STB]) stb_at = n;
      if (rx_at < 0 && rx_downstream_debug_status[18]) rx_at = n;
    end
    compare_hex("marker in tx_phy cycles", FLIT_W'(mrk_at), FLIT_W'(1));
    compare_hex("strobe in tx_phy cycles", FLIT_W'(stb_at), FLIT_W'(DLY_Z + 1));
    compare_hex("rx_online_delay rise cycles", FLIT_W'(rx_at), FLIT_W'(DLY_Y + 1));
    compare_hex("tx_upstream_debug_status", FLIT_W'(tx_upstream_debug_status),
                FLIT_W'(32'h000c_0000));
    compare_hex("rx_downstream_debug_status", FLIT_W'(rx_downstream_debug_status),
                FLIT_W'(32'h000c_0000));
    tx_online = 1'b0;
    step_cycle;
    compare_hex("tx_online_delay", FLIT_W'(tx_upstream_debug_status[19]), '0);
    step_cycle;
    check_tx_phy('0);
    finish_test("online sequencing");
  endtask

  task automatic test_transmit;
    logic [FLIT_W-1:0] f;
    bring_online;
    repeat (8) begin
      random_flit(f);
      drive_ustrm(f);
      step_cycle;
      check_tx_phy(pack_lanes(f, 1'b1, 1'b1));
    end
    finish_test("transmit mapping");
  endtask

  task automatic test_receive;
    logic [FLIT_W-1:0] f;
    repeat (8) begin
      random_flit(f);
      rx_phy_drv = pack_lanes(f, 1'b1, 1'b1);
      step_cycle;
      check_dstrm(f);
    end
    finish_test("receive mapping");
  endtask

  task automatic test_qualify;
    logic [FLIT_W-1:0]                f;
    logic [NUM_LANES-1:0][LANE_W-1:0] lanes;
    // Drop one lane's strobe, then one lane's marker
    for (int i = 0; i < 2 * NUM_LANES; i++) begin
      random_flit(f);
      lanes = pack_lanes(f, 1'b1, 1'b1);
      if (i < NUM_LANES) begin
        lanes[i][STB] = 1'b0;
      end else begin
        lanes[i - NUM_LANES][MRK] = 1'b0;
      end
      rx_phy_drv = lanes;
      step_cycle;
      check_dstrm('0);
    end
    random_flit(f);
    rx_phy_drv = pack_lanes(f, 1'b1, 1'b1);
    step_cycle;
    check_dstrm(f);
    // Word still passes on the edge where rx online falls
    rx_online = 1'b0;
    step_cycle;
    compare_hex("rx_online_delay", FLIT_W'(rx_downstream_debug_status[18]), '0);
    step_cycle;
    check_dstrm('0);
    bring_online;
    finish_test("receive qualification");
  endtask

  task automatic test_loopback;
    logic [FLIT_W-1:0] f;
    logic [FLIT_W-1:0] sent[$];
    loopback = 1'b1;
    for (int i = 0; i <= LOOP_FLITS; i++) begin
      if (i < LOOP_FLITS) begin
        random_flit(f);
        drive_ustrm(f);
        sent.push_back(f);
      end
      step_cycle;
      // Flit from two edges back
      if (i >= 1) check_dstrm(sent.pop_front());
    end
    loopback = 1'b0;
    finish_test("loopback");
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    tx_online     = 1'b0;
    rx_online     = 1'b0;
    delay_x_value = 16'(DLY_X);
    delay_y_value = 16'(DLY_Y);
    delay_z_value = 16'(DLY_Z);
    loopback      = 1'b0;
    rx_phy_drv    = '0;
    lfsr          = 32'hfa0b;
    errors        = 0;
    pass_count    = 0;
    fail_count    = 0;
    drive_ustrm('0);
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_reset;
    test_online;
    test_transmit;
    test_receive;
    test_qualify;
    test_loopback;
    $display("tests passed %0d failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
